// File: Bender.yml
package:
  name: gshare_fetch

sources:
  - files:
      - verilog/gshare_fetch_pkg.sv
      - verilog/branch_target_buffer.sv
      - verilog/pattern_history_table.sv
      - verilog/fetch_unit.sv
      - verilog/branch_resolve.sv
      - verilog/gshare_fetch_top.sv
  - target: test
    files:
      - dv/gshare_fetch_clock_gen.sv
      - dv/gshare_fetch_sva.sv
      - dv/gshare_fetch_tb.sv

// File: dv/gshare_fetch_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module gshare_fetch_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;        // 20 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);     // four reset edges
    reset <= 1'b0;                 // drops just after the fourth edge
  end

endmodule

`default_nettype wire

// File: dv/gshare_fetch_sva.sv
`timescale 1ns/1ns
`default_nettype none

module gshare_fetch_sva (
  input wire                      clk,
  input wire                      reset,
  input wire                      fetch_stall,
  input wire                      resolve_valid,
  input wire                      redirect,
  input gshare_fetch_pkg::addr_t  redirect_pc,
  input gshare_fetch_pkg::addr_t  fetch_pc
);

  // stall without redirect keeps the pc
  property stall_holds_pc;
    @(posedge clk) disable iff (reset)
      (fetch_stall && !redirect) |=> $stable(fetch_pc);
  endproperty

  // redirect lands one cycle later, stall or not
  property redirect_lands;
    @(posedge clk) disable iff (reset)
      redirect |=> (fetch_pc == $past(redirect_pc));
  endproperty

  property idle_no_redirect;
    @(posedge clk) disable iff (reset)
      !resolve_valid |-> !redirect;
  endproperty

  a_stall_holds_pc: assert property (stall_holds_pc)
    else $error("fetch_pc moved during a stall without redirect");
  a_redirect_lands: assert property (redirect_lands)
    else $error("fetch_pc did not take the previous redirect_pc");
  a_idle_no_redirect: assert property (idle_no_redirect)
    else $error("redirect high without resolve_valid");

endmodule

bind gshare_fetch_top gshare_fetch_sva u_sva (.*);

`default_nettype wire

// File: dv/gshare_fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module gshare_fetch_tb;

  logic clk;
  logic reset;
  logic fetch_stall;
  logic resolve_valid;
  gshare_fetch_pkg::addr_t resolve_pc;
  gshare_fetch_pkg::cf_kind_t resolve_kind;
  logic resolve_bcond;
  gshare_fetch_pkg::word_t resolve_imm;
  gshare_fetch_pkg::addr_t resolve_jalr_target;
  gshare_fetch_pkg::addr_t resolve_pred_next_pc;
  gshare_fetch_pkg::pht_index_t resolve_pht_index;
  gshare_fetch_pkg::addr_t fetch_pc;
  gshare_fetch_pkg::addr_t fetch_pred_next_pc;
  gshare_fetch_pkg::pht_index_t fetch_pht_index;
  logic redirect;
  gshare_fetch_pkg::addr_t redirect_pc;

  gshare_fetch_pkg::cf_kind_t prog_kind [32];   // one slot per word, 0x00..0x7c
  gshare_fetch_pkg::word_t prog_imm [32];
  int branch_visits;                            // drives the bcond pattern
  int jalr_visits;                              // drives the jalr target

  logic m_btb_valid [32];                       // reference predictor state
  gshare_fetch_pkg::btb_tag_t m_btb_tag [32];
  gshare_fetch_pkg::addr_t m_btb_target [32];
  logic m_btb_uncond [32];
  gshare_fetch_pkg::counter_t m_pht [32];
  gshare_fetch_pkg::bhr_t m_bhr;
  gshare_fetch_pkg::addr_t m_pc;

  gshare_fetch_pkg::addr_t exp_pred;            // expected for this cycle
  gshare_fetch_pkg::pht_index_t exp_index;
  gshare_fetch_pkg::addr_t exp_actual;
  logic exp_redirect;
  logic corrupted;                              // echoed prediction was scrambled
  logic driven;
  logic stall_enable;
  logic [15:0] lfsr_state;

  gshare_fetch_pkg::addr_t fl_pc [$];           // in flight, oldest first
  gshare_fetch_pkg::addr_t fl_pred [$];
  gshare_fetch_pkg::pht_index_t fl_index [$];

  int checks, errors, fetches, dut_redirects, stall_redirects;
  int jal0_resolves, jal0_redirects, branch_resolves, branch_pred_taken, nt_redirects;
  int jalr_resolves, jalr_redirects, none_corrupted, none_redirects;
  int corrupt_base;                             // corrupted count when test 6 starts

  gshare_fetch_clock_gen u_clock_gen (.clk(clk), .reset(reset));

  gshare_fetch_top UUT (
    .clk(clk), .reset(reset), .fetch_stall(fetch_stall), .resolve_valid(resolve_valid),
    .resolve_pc(resolve_pc), .resolve_kind(resolve_kind), .resolve_bcond(resolve_bcond),
    .resolve_imm(resolve_imm), .resolve_jalr_target(resolve_jalr_target),
    .resolve_pred_next_pc(resolve_pred_next_pc), .resolve_pht_index(resolve_pht_index),
    .fetch_pc(fetch_pc), .fetch_pred_next_pc(fetch_pred_next_pc),
    .fetch_pht_index(fetch_pht_index), .redirect(redirect), .redirect_pc(redirect_pc)
  );

  // x^16 + x^14 + x^13 + x^11
  function automatic logic random_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic gshare_fetch_pkg::pht_index_t ref_index(input gshare_fetch_pkg::addr_t pc);
    return pc[6:2] ^ m_bhr;                     // gshare hash
  endfunction

  function automatic gshare_fetch_pkg::addr_t ref_pred_next(input gshare_fetch_pkg::addr_t pc);
    int slot;
    logic hit;
    gshare_fetch_pkg::addr_t next;
    slot = pc[6:2];
    hit = m_btb_valid[slot] && (m_btb_tag[slot] == pc[31:7]);
    next = pc + 32'd4;
    if (hit && (m_btb_uncond[slot] || (m_pht[ref_index(pc)] >= 2'd2))) next = m_btb_target[slot];
    return next;
  endfunction

  function automatic gshare_fetch_pkg::addr_t ref_actual_next(input gshare_fetch_pkg::addr_t pc,
      input gshare_fetch_pkg::cf_kind_t kind, input logic bcond,
      input gshare_fetch_pkg::word_t imm, input gshare_fetch_pkg::addr_t jt);
    gshare_fetch_pkg::addr_t next;
    next = pc + 32'd4;                          // fall through by default
    if (kind == gshare_fetch_pkg::cf_jal) next = pc + imm;
    if (kind == gshare_fetch_pkg::cf_jalr) next = jt;
    if (kind == gshare_fetch_pkg::cf_branch && bcond) next = pc + imm;
    return next;
  endfunction

  task automatic check_addr(input string name, input gshare_fetch_pkg::addr_t got,
                            input gshare_fetch_pkg::addr_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, want);
    end
  endtask

  task automatic check_index(input string name, input gshare_fetch_pkg::pht_index_t got,
                             input gshare_fetch_pkg::pht_index_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
      m_btb_valid[i] = 1'b0;
      m_pht[i] = 2'd1;                          // weakly not taken
    end
    m_bhr = '0;
    m_pc = 32'h0;
    driven = 1'b0;
    fl_pc.delete();
    fl_pred.delete();
    fl_index.delete();
  endtask

  // resolves the oldest in-flight entry before the new fetch
  task automatic drive_cycle();
    int slot;
    logic b0;
    logic b1;
    fetch_stall = 1'b0;
    if (stall_enable) begin
      b0 = random_bit();
      b1 = random_bit();
      fetch_stall = b0 && b1;                   // about one cycle in four
    end
    resolve_valid = 1'b0;
    resolve_pc = '0;
    resolve_kind = gshare_fetch_pkg::cf_none;
    resolve_bcond = 1'b0;
    resolve_imm = '0;
    resolve_jalr_target = '0;
    resolve_pred_next_pc = '0;
    resolve_pht_index = '0;
    corrupted = 1'b0;
    if (fl_pc.size() == 2) begin
      resolve_valid = 1'b1;
      resolve_pc = fl_pc.pop_front();
      resolve_pred_next_pc = fl_pred.pop_front();
      resolve_pht_index = fl_index.pop_front();
      slot = resolve_pc[6:2];
      resolve_kind = prog_kind[slot];
      resolve_imm = prog_imm[slot];
      if (resolve_kind == gshare_fetch_pkg::cf_branch) begin
        resolve_bcond = (branch_visits % 8) != 7; // seven taken, one exit
        branch_visits++;
      end
      if (resolve_kind == gshare_fetch_pkg::cf_jalr) begin
        resolve_jalr_target = (jalr_visits % 2 == 0) ? 32'h00 : 32'h40;
        jalr_visits++;
      end
      if (resolve_kind == gshare_fetch_pkg::cf_none) begin
        corrupted = random_bit();
        if (corrupted) resolve_pred_next_pc = resolve_pred_next_pc ^ 32'h100;
      end
    end
    exp_actual = ref_actual_next(resolve_pc, resolve_kind, resolve_bcond, resolve_imm,
                                 resolve_jalr_target);
    exp_redirect = resolve_valid && (resolve_kind != gshare_fetch_pkg::cf_none) &&
                   (exp_actual != resolve_pred_next_pc);
    exp_pred = ref_pred_next(m_pc);
    exp_index = ref_index(m_pc);
    if (exp_redirect) begin
      fl_pc.delete();                           // younger entries are wrong path
      fl_pred.delete();
      fl_index.delete();
    end else if (!fetch_stall) begin
      fl_pc.push_back(m_pc);
      fl_pred.push_back(exp_pred);
      fl_index.push_back(exp_index);
    end
    driven = 1'b1;
  endtask

  task automatic count_events();
    if (!fetch_stall && !exp_redirect) begin
      fetches++;
      if (fetch_pc == 32'h34 && fetch_pred_next_pc == 32'h2c) branch_pred_taken++;
    end
    if (redirect) dut_redirects++;
    if (redirect && fetch_stall) stall_redirects++;
    if (resolve_valid) begin
      case (resolve_kind)
        gshare_fetch_pkg::cf_jal: begin
          if (resolve_pc == 32'h0c) jal0_resolves++;
          if (resolve_pc == 32'h0c && redirect) jal0_redirects++;
        end
        gshare_fetch_pkg::cf_branch: begin
          branch_resolves++;
          if (!resolve_bcond && redirect && redirect_pc == resolve_pc + 32'd4) nt_redirects++;
        end
        gshare_fetch_pkg::cf_jalr: begin
          jalr_resolves++;
          if (redirect) jalr_redirects++;
        end
        default: begin
          if (corrupted) none_corrupted++;
          if (redirect) none_redirects++;
        end
      endcase
    end
  endtask

  task automatic update_model();
    int slot;
    slot = resolve_pc[6:2];
    if (resolve_valid && (resolve_kind == gshare_fetch_pkg::cf_jal ||
        resolve_kind == gshare_fetch_pkg::cf_jalr ||
        (resolve_kind == gshare_fetch_pkg::cf_branch && resolve_bcond))) begin
      m_btb_valid[slot] = 1'b1;
      m_btb_tag[slot] = resolve_pc[31:7];
      m_btb_target[slot] = exp_actual;
      m_btb_uncond[slot] = resolve_kind != gshare_fetch_pkg::cf_branch;
    end
    if (resolve_valid && resolve_kind == gshare_fetch_pkg::cf_branch) begin
      if (resolve_bcond && m_pht[resolve_pht_index] != 2'd3) m_pht[resolve_pht_index]++;
      if (!resolve_bcond && m_pht[resolve_pht_index] != 2'd0) m_pht[resolve_pht_index]--;
      m_bhr = {m_bhr[3:0], resolve_bcond};      // newest outcome in lsb
    end
    if (exp_redirect) m_pc = exp_actual;
    else if (!fetch_stall) m_pc = exp_pred;
  endtask

  always @(negedge clk) begin
    if (!reset) drive_cycle();
  end

  // compare first and then advance the model
  always @(posedge clk) begin
    if (reset) begin
      reset_model();
    end else if (driven) begin
      check_addr("fetch_pc", fetch_pc, m_pc);
      check_addr("fetch_pred_next_pc", fetch_pred_next_pc, exp_pred);
      check_index("fetch_pht_index", fetch_pht_index, exp_index);
      check_bit("redirect", redirect, exp_redirect);
      if (resolve_valid) check_addr("redirect_pc", redirect_pc, exp_actual);
      count_events();
      update_model();
    end
  end

  function automatic bit goal_met(input int test_id);
    case (test_id)
      1: return fetches >= 4;
      2: return jal0_resolves >= 2;
      3: return branch_resolves >= 24;
      4: return jalr_resolves >= 3;
      5: return stall_redirects >= 3;
      default: return (none_corrupted - corrupt_base) >= 4;
    endcase
  endfunction

  task automatic wait_goal(input int test_id, input int limit);
    int n;
    n = 0;
    while (!goal_met(test_id) && n < limit) begin
      @(negedge clk);                           // counters settle at the rising edge
      n++;
    end
    if (!goal_met(test_id)) begin
      errors++;
      $display("test %0d timed out after %0d cycles", test_id, limit);
    end
  endtask

  task automatic require(input bit cond, input string what);
    if (!cond) begin
      errors++;
      $display("check failed at %0t: %s", $time, what);
    end
  endtask

  task automatic report_test(input int test_id, input string name, input int err_before);
    $display("test %0d %s: %s (%0d errors)", test_id, name,
             (errors == err_before) ? "pass" : "fail", errors - err_before);
  endtask

  task automatic set_stall_mode(input logic en);
    @(posedge clk);                             // away from the driving edge
    stall_enable = en;
  endtask

  initial begin
    int err_before;
    int n;
    fetch_stall = 1'b0;
    resolve_valid = 1'b0;
    resolve_pc = '0;
    resolve_kind = gshare_fetch_pkg::cf_none;
    resolve_bcond = 1'b0;
    resolve_imm = '0;
    resolve_jalr_target = '0;
    resolve_pred_next_pc = '0;
    resolve_pht_index = '0;
    stall_enable = 1'b0;
    driven = 1'b0;
    corrupt_base = 0;
    lfsr_state = 16'd56864;
    for (int i = 0; i < 32; i++) begin
      prog_kind[i] = gshare_fetch_pkg::cf_none;
      prog_imm[i] = '0;
    end
    prog_kind[3] = gshare_fetch_pkg::cf_jal;    // 0x0c jumps to 0x2c
    prog_imm[3] = 32'h20;
    prog_kind[13] = gshare_fetch_pkg::cf_branch; // 0x34 loops back to 0x2c
    prog_imm[13] = 32'hffff_fff8;
    prog_kind[14] = gshare_fetch_pkg::cf_jalr;  // 0x38 alternates 0x00 and 0x40
    prog_kind[17] = gshare_fetch_pkg::cf_jal;   // 0x44 back to 0x00
    prog_imm[17] = 32'hffff_ffbc;
    n = 0;
    while (reset !== 1'b0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (reset !== 1'b0) begin
      errors++;
      $display("reset never released");
    end
    err_before = errors;
    wait_goal(1, 20);
    require(dut_redirects == 0, "redirect seen during sequential fetch");
    report_test(1, "reset and sequential fetch", err_before);
    err_before = errors;
    wait_goal(2, 400);
    require(jal0_redirects == 1, "jal should redirect on its first visit only");
    report_test(2, "jal btb fill", err_before);
    err_before = errors;
    wait_goal(3, 1000);
    require(branch_pred_taken > 0, "loop branch never predicted taken");
    require(nt_redirects > 0, "loop exit never redirected to pc+4");
    report_test(3, "loop branch", err_before);
    err_before = errors;
    wait_goal(4, 600);
    require(jalr_redirects == jalr_resolves, "jalr with a new target did not redirect");
    report_test(4, "jalr target change", err_before);
    err_before = errors;
    set_stall_mode(1'b1);
    wait_goal(5, 4000);
    set_stall_mode(1'b0);
    report_test(5, "stalls and redirect under stall", err_before);
    err_before = errors;
    corrupt_base = none_corrupted;
    wait_goal(6, 2000);
    require(none_redirects == 0, "plain instruction caused a redirect");
    report_test(6, "plain instructions", err_before);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: gshare_fetch.f
verilog/gshare_fetch_pkg.sv
verilog/branch_target_buffer.sv
verilog/pattern_history_table.sv
verilog/fetch_unit.sv
verilog/branch_resolve.sv
verilog/gshare_fetch_top.sv
dv/gshare_fetch_clock_gen.sv
dv/gshare_fetch_sva.sv
dv/gshare_fetch_tb.sv

// File: verilog/branch_resolve.sv
`timescale 1ns/1ns
`default_nettype none

module branch_resolve (
  input  wire                         resolve_valid,
  input  gshare_fetch_pkg::addr_t     resolve_pc,
  input  gshare_fetch_pkg::cf_kind_t  resolve_kind,
  input  wire                         resolve_bcond,         // branch condition met
  input  gshare_fetch_pkg::word_t     resolve_imm,
  input  gshare_fetch_pkg::addr_t     resolve_jalr_target,
  input  gshare_fetch_pkg::addr_t     resolve_pred_next_pc,  // what fetch guessed
  output logic                        redirect,
  output gshare_fetch_pkg::addr_t     redirect_pc,           // actual next pc
  output logic                        btb_write_en,
  output logic                        btb_write_uncond,
  output logic                        pht_update_en,
  output logic                        pht_update_taken
);

  gshare_fetch_pkg::addr_t seq_pc;     // pc + 4
  gshare_fetch_pkg::addr_t rel_pc;     // pc + imm
  logic is_branch;
  logic is_jump;                       // jal or jalr
  logic actual_taken;

  assign seq_pc = resolve_pc + gshare_fetch_pkg::INSTR_BYTES;
  assign rel_pc = resolve_pc + resolve_imm;

  assign is_branch = (resolve_kind == gshare_fetch_pkg::cf_branch);
  assign is_jump   = (resolve_kind == gshare_fetch_pkg::cf_jal) ||
                     (resolve_kind == gshare_fetch_pkg::cf_jalr);
  assign actual_taken = is_jump || (is_branch && resolve_bcond);

  always_comb begin
    case (resolve_kind)
      gshare_fetch_pkg::cf_jal:    redirect_pc = rel_pc;
      gshare_fetch_pkg::cf_jalr:   redirect_pc = resolve_jalr_target;
      gshare_fetch_pkg::cf_branch: redirect_pc = resolve_bcond ? rel_pc : seq_pc;
      default:                     redirect_pc = seq_pc;     // no control flow
    endcase
  end

  // plain instructions never redirect
  assign redirect = resolve_valid && (resolve_kind != gshare_fetch_pkg::cf_none) &&
                    (redirect_pc != resolve_pred_next_pc);

  assign btb_write_en     = resolve_valid && actual_taken;   // only taken targets stored
  assign btb_write_uncond = is_jump;
  assign pht_update_en    = resolve_valid && is_branch;
  assign pht_update_taken = resolve_bcond;

endmodule

`default_nettype wire

// File: verilog/branch_target_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module branch_target_buffer (
  input  wire                        clk,
  input  wire                        reset,
  input  gshare_fetch_pkg::addr_t    lookup_pc,     // current fetch address
  input  wire                        write_en,      // taken outcome from resolve
  input  gshare_fetch_pkg::addr_t    write_pc,      // pc of resolved instruction
  input  gshare_fetch_pkg::addr_t    write_target,  // actual target
  input  wire                        write_uncond,  // jal or jalr
  output logic                       hit,
  output logic                       uncond,
  output gshare_fetch_pkg::addr_t    target
);

  logic [$clog2(gshare_fetch_pkg::BTB_ENTRIES)-1:0] lookup_idx;  // read slot
  logic [$clog2(gshare_fetch_pkg::BTB_ENTRIES)-1:0] write_idx;   // write slot
  gshare_fetch_pkg::btb_tag_t lookup_tag;
  gshare_fetch_pkg::btb_tag_t write_tag;

  logic [gshare_fetch_pkg::BTB_ENTRIES-1:0] valid_q;          // per entry valid
  gshare_fetch_pkg::btb_tag_t tag_q [gshare_fetch_pkg::BTB_ENTRIES];
  gshare_fetch_pkg::addr_t target_q [gshare_fetch_pkg::BTB_ENTRIES];
  logic uncond_q [gshare_fetch_pkg::BTB_ENTRIES];              // jump, not branch

  assign lookup_idx = lookup_pc[6:2];   // word aligned, low bits dropped
  assign lookup_tag = lookup_pc[31:7];
  assign write_idx  = write_pc[6:2];
  assign write_tag  = write_pc[31:7];

  // combinational lookup
  assign hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign uncond = uncond_q[lookup_idx];
  assign target = target_q[lookup_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;                    // all entries invalid
    end else if (write_en) begin
      valid_q[write_idx] <= 1'b1;
    end
  end

  // payload arrays, qualified by valid_q
  always_ff @(posedge clk) begin
    if (write_en) begin
      tag_q[write_idx]    <= write_tag;
      target_q[write_idx] <= write_target;
      uncond_q[write_idx] <= write_uncond;  // later hits skip the counter
    end
  end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        fetch_stall,   // hold pc
  input  wire                        redirect,      // misprediction from resolve
  input  gshare_fetch_pkg::addr_t    redirect_pc,   // corrected address
  input  wire                        btb_hit,
  input  wire                        btb_uncond,
  input  gshare_fetch_pkg::addr_t    btb_target,
  input  wire                        pht_taken,     // counter says taken
  output gshare_fetch_pkg::addr_t    fetch_pc,
  output gshare_fetch_pkg::addr_t    fetch_pred_next_pc
);

  gshare_fetch_pkg::addr_t pc_q;
  gshare_fetch_pkg::addr_t pc_seq;   // fall through address
  logic predict_jump;                // follow the btb

  assign pc_seq = pc_q + gshare_fetch_pkg::INSTR_BYTES;

  // jumps always follow a hit, branches only when the counter agrees
  assign predict_jump = btb_hit && (btb_uncond || pht_taken);

  assign fetch_pred_next_pc = predict_jump ? btb_target : pc_seq;
  assign fetch_pc = pc_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= gshare_fetch_pkg::PC_RESET;
    end else if (redirect) begin
      pc_q <= redirect_pc;             // wins over stall
    end else if (!fetch_stall) begin
      pc_q <= fetch_pred_next_pc;
    end
  end

endmodule

`default_nettype wire

// File: verilog/gshare_fetch_pkg.sv
`default_nettype none

package gshare_fetch_pkg;

  localparam int PHT_INDEX_W = 5;             // gshare index and history width

  typedef logic [31:0] word_t;                // immediate or jalr target value
  typedef logic [31:0] addr_t;                // instruction address
  typedef logic [PHT_INDEX_W-1:0] pht_index_t; // pht slot
  typedef logic [PHT_INDEX_W-1:0] bhr_t;       // global branch history
  typedef logic [1:0] counter_t;               // two-bit saturating counter
  typedef logic [24:0] btb_tag_t;              // pc bits 31:7

  // kind of control flow reported by the execute side
  typedef enum logic [1:0] {
    cf_none   = 2'd0,                          // plain instruction
    cf_branch = 2'd1,                          // conditional branch
    cf_jal    = 2'd2,                          // pc relative jump
    cf_jalr   = 2'd3                           // register indirect jump
  } cf_kind_t;

  localparam int PHT_ENTRIES = 32;             // one counter per index value
  localparam int BTB_ENTRIES = 32;             // direct mapped on pc bits 6:2

  localparam addr_t INSTR_BYTES = 32'd4;       // fixed instruction size
  localparam addr_t PC_RESET = 32'h0000_0000;  // first fetch address

  localparam counter_t COUNTER_INIT = 2'd1;      // weakly not taken
  localparam counter_t COUNTER_TAKEN_MIN = 2'd2; // weakly taken and up

endpackage

`default_nettype wire

// File: verilog/gshare_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module gshare_fetch_top (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           fetch_stall,
  input  wire                           resolve_valid,
  input  gshare_fetch_pkg::addr_t       resolve_pc,
  input  gshare_fetch_pkg::cf_kind_t    resolve_kind,
  input  wire                           resolve_bcond,
  input  gshare_fetch_pkg::word_t       resolve_imm,
  input  gshare_fetch_pkg::addr_t       resolve_jalr_target,
  input  gshare_fetch_pkg::addr_t       resolve_pred_next_pc,  // echoed from fetch
  input  gshare_fetch_pkg::pht_index_t  resolve_pht_index,     // echoed from fetch
  output gshare_fetch_pkg::addr_t       fetch_pc,
  output gshare_fetch_pkg::addr_t       fetch_pred_next_pc,
  output gshare_fetch_pkg::pht_index_t  fetch_pht_index,
  output logic                          redirect,
  output gshare_fetch_pkg::addr_t       redirect_pc
);

  logic btb_hit;
  logic btb_uncond;
  gshare_fetch_pkg::addr_t btb_target;
  logic pht_taken;
  logic btb_write_en;
  logic btb_write_uncond;
  logic pht_update_en;
  logic pht_update_taken;

  fetch_unit u_fetch_unit (
    .clk                (clk),
    .reset              (reset),
    .fetch_stall        (fetch_stall),
    .redirect           (redirect),
    .redirect_pc        (redirect_pc),
    .btb_hit            (btb_hit),
    .btb_uncond         (btb_uncond),
    .btb_target         (btb_target),
    .pht_taken          (pht_taken),
    .fetch_pc           (fetch_pc),
    .fetch_pred_next_pc (fetch_pred_next_pc)
  );

  branch_target_buffer u_btb (
    .clk          (clk),
    .reset        (reset),
    .lookup_pc    (fetch_pc),
    .write_en     (btb_write_en),
    .write_pc     (resolve_pc),
    .write_target (redirect_pc),      // actual next pc of a taken instruction
    .write_uncond (btb_write_uncond),
    .hit          (btb_hit),
    .uncond       (btb_uncond),
    .target       (btb_target)
  );

  pattern_history_table u_pht (
    .clk           (clk),
    .reset         (reset),
    .lookup_pc     (fetch_pc),
    .update_en     (pht_update_en),
    .update_index  (resolve_pht_index),  // index seen at fetch, not rehashed
    .update_taken  (pht_update_taken),
    .lookup_index  (fetch_pht_index),
    .predict_taken (pht_taken)
  );

  branch_resolve u_resolve (
    .resolve_valid        (resolve_valid),
    .resolve_pc           (resolve_pc),
    .resolve_kind         (resolve_kind),
    .resolve_bcond        (resolve_bcond),
    .resolve_imm          (resolve_imm),
    .resolve_jalr_target  (resolve_jalr_target),
    .resolve_pred_next_pc (resolve_pred_next_pc),
    .redirect             (redirect),
    .redirect_pc          (redirect_pc),
    .btb_write_en         (btb_write_en),
    .btb_write_uncond     (btb_write_uncond),
    .pht_update_en        (pht_update_en),
    .pht_update_taken     (pht_update_taken)
  );

endmodule

`default_nettype wire

// File: verilog/pattern_history_table.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_history_table (
  input  wire                           clk,
  input  wire                           reset,
  input  gshare_fetch_pkg::addr_t       lookup_pc,     // current fetch address
  input  wire                           update_en,     // valid branch resolve
  input  gshare_fetch_pkg::pht_index_t  update_index,  // index used at fetch time
  input  wire                           update_taken,  // branch outcome
  output gshare_fetch_pkg::pht_index_t  lookup_index,  // echoed down the pipe
  output logic                          predict_taken
);

  gshare_fetch_pkg::bhr_t bhr_q;                                     // global history
  gshare_fetch_pkg::counter_t counter_q [gshare_fetch_pkg::PHT_ENTRIES];
  gshare_fetch_pkg::counter_t cur_count;                             // counter under update

  // gshare hash
  assign lookup_index  = lookup_pc[6:2] ^ bhr_q;
  assign predict_taken = counter_q[lookup_index] >= gshare_fetch_pkg::COUNTER_TAKEN_MIN;

  assign cur_count = counter_q[update_index];

  always_ff @(posedge clk) begin
    if (reset) begin
      bhr_q <= '0;
    end else if (update_en) begin
      bhr_q <= {bhr_q[gshare_fetch_pkg::PHT_INDEX_W-2:0], update_taken};  // newest in lsb
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < gshare_fetch_pkg::PHT_ENTRIES; i++) begin
        counter_q[i] <= gshare_fetch_pkg::COUNTER_INIT;  // weakly not taken
      end
    end else if (update_en) begin
      if (update_taken) begin
        if (cur_count != 2'b11) begin
          counter_q[update_index] <= cur_count + 2'd1;   // step toward taken
        end
      end else begin
        if (cur_count != 2'b00) begin
          counter_q[update_index] <= cur_count - 2'd1;   // step toward not taken
        end
      end
    end
  end

endmodule

`default_nettype wire
